// File: Makefile
# Verilator build and run for the CCI-P sniffer testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= sniffer_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
rtl/sniffer_pkg.sv
rtl/c0_read_checker.sv
rtl/c1_write_checker.sv
rtl/mmio_rsp_tracker.sv
rtl/ccip_sniffer.sv
tests/sniffer_props.sv
tests/sniffer_tb.sv

// File: rtl/c0_read_checker.sv
// Rule checks on channel 0 read requests
// Flags are registered, one cycle per offending beat
`timescale 1ns/1ps

module c0_read_checker
   import sniffer_pkg::*;
(
   input  logic     clk,
   input  logic     ase_reset,
   input  logic     soft_reset,
   input  c0_tx_t   c0_tx,
   input  logic     c0_full,
   output err_vec_t err
);

   err_vec_t err_next;
   logic     type_ok;

   // Only the two read flavours are legal here
   assign type_ok = c0_tx.req_type inside {REQ_RDLINE_S, REQ_RDLINE_I};

   always_comb begin
      err_next = '0;
      if (c0_tx.valid) begin
         if (soft_reset) begin
            // AFU still issuing while held in reset
            err_next[SNIFF_C0TX_RESET_IGNORED_WARN] = 1'b1;
         end else begin
            err_next[SNIFF_C0TX_INVALID_REQTYPE] = !type_ok;
            err_next[SNIFF_C0TX_OVERFLOW]        = c0_full;
            err_next[SNIFF_C0TX_3CL_REQUEST]     = (c0_tx.cl_len == CL_LEN_3);
            // 2-line needs even address
            err_next[SNIFF_C0TX_ADDRALIGN_2_ERROR] =
               (c0_tx.cl_len == CL_LEN_2) && c0_tx.address[0];
            // 4-line needs address[1:0] == 0
            err_next[SNIFF_C0TX_ADDRALIGN_4_ERROR] =
               (c0_tx.cl_len == CL_LEN_4) && (c0_tx.address[1:0] != 2'b00);
            err_next[SNIFF_C0TX_ADDR_ZERO_WARN] = (c0_tx.address == '0);
         end
      end
   end

   // One-cycle pulse after the sampling edge
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         err <= '0;
      end else begin
         err <= err_next;
      end
   end

endmodule

// File: rtl/c1_write_checker.sv
// Channel 1 write checker, tracks multi-line bursts beat by beat
// Base fields come from the first beat of each burst
// Flags are registered, one cycle per offending beat
`timescale 1ns/1ps

module c1_write_checker
   import sniffer_pkg::*;
(
   input  logic     clk,
   input  logic     ase_reset,
   input  logic     soft_reset,
   input  c1_tx_t   c1_tx,
   input  logic     c1_full,
   output err_vec_t err
);

   c1_state_e              state;
   c1_state_e              state_next;
   err_vec_t               err_next;
   logic [1:0]             base_addr_low;
   logic [1:0]             base_vc_sel;
   cl_len_e                base_cl_len;
   logic [MDATA_WIDTH-1:0] base_mdata;
   c1_req_e                base_req_type;
   logic [1:0]             exp_addr_low;
   logic                   type_ok;
   logic                   is_fence;
   logic                   is_write;
   logic                   burst_start;

   assign type_ok = c1_tx.req_type inside {REQ_WRLINE_I, REQ_WRLINE_M,
                                           REQ_WRPUSH_I, REQ_WRFENCE};
   assign is_fence = type_ok && (c1_tx.req_type == REQ_WRFENCE);
   assign is_write = type_ok && !is_fence;

   // State value doubles as beat offset from base
   assign exp_addr_low = base_addr_low + 2'(state);

   // First beat of a new burst
   assign burst_start = c1_tx.valid && !soft_reset && is_write && c1_tx.sop &&
                        (state == C1_EXPECT_SOP);

   always_comb begin
      err_next   = '0;
      state_next = state;
      if (soft_reset) begin
         // Burst abandoned, only the reset warning is raised
         state_next = C1_EXPECT_SOP;
         err_next[SNIFF_C1TX_RESET_IGNORED_WARN] = c1_tx.valid;
      end else if (c1_tx.valid) begin
         err_next[SNIFF_C1TX_OVERFLOW] = c1_full;
         if (!type_ok) begin
            err_next[SNIFF_C1TX_INVALID_REQTYPE] = 1'b1;
         end else if (is_fence) begin
            // Fences never move the state
            err_next[SNIFF_C1TX_WRFENCE_SOP_SET]    = c1_tx.sop;
            err_next[SNIFF_C1TX_WRFENCE_IN_MCL1TO3] = (state != C1_EXPECT_SOP);
         end else if (state == C1_EXPECT_SOP) begin
            if (!c1_tx.sop) begin
               err_next[SNIFF_C1TX_SOP_NOT_SET] = 1'b1;
            end else begin
               err_next[SNIFF_C1TX_3CL_REQUEST] = (c1_tx.cl_len == CL_LEN_3);
               err_next[SNIFF_C1TX_ADDRALIGN_2_ERROR] =
                  (c1_tx.cl_len == CL_LEN_2) && c1_tx.address[0];
               err_next[SNIFF_C1TX_ADDRALIGN_4_ERROR] =
                  (c1_tx.cl_len == CL_LEN_4) && (c1_tx.address[1:0] != 2'b00);
               err_next[SNIFF_C1TX_ADDR_ZERO_WARN] = (c1_tx.address == '0);
               // Multi-line bursts wait for beat 2
               if (c1_tx.cl_len inside {CL_LEN_2, CL_LEN_4}) begin
                  state_next = C1_BEAT_2;
               end
            end
         end else begin
            // Later beats must repeat the base header
            err_next[SNIFF_C1TX_UNEXP_ADDR]    = (c1_tx.address[1:0] != exp_addr_low);
            err_next[SNIFF_C1TX_UNEXP_CLLEN]   = (c1_tx.cl_len != base_cl_len);
            err_next[SNIFF_C1TX_UNEXP_VCSEL]   = (c1_tx.vc_sel != base_vc_sel);
            err_next[SNIFF_C1TX_UNEXP_MDATA]   = (c1_tx.mdata != base_mdata);
            err_next[SNIFF_C1TX_UNEXP_REQTYPE] = (c1_tx.req_type != base_req_type);
            err_next[SNIFF_C1TX_SOP_SET_MCL1TO3] = c1_tx.sop;
            case (state)
               C1_BEAT_2: begin
                  // 2-line burst ends here
                  if (base_cl_len == CL_LEN_4) begin
                     state_next = C1_BEAT_3;
                  end else begin
                     state_next = C1_EXPECT_SOP;
                  end
               end
               C1_BEAT_3: state_next = C1_BEAT_4;
               default:   state_next = C1_EXPECT_SOP;
            endcase
         end
      end
   end

   // State and flags
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         state <= C1_EXPECT_SOP;
         err   <= '0;
      end else begin
         state <= state_next;
         err   <= err_next;
      end
   end

   // Base capture on burst start
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         base_addr_low <= 2'b00;
         base_vc_sel   <= 2'b00;
         base_cl_len   <= CL_LEN_1;
         base_mdata    <= '0;
         base_req_type <= REQ_WRLINE_I;
      end else if (burst_start) begin
         base_addr_low <= c1_tx.address[1:0];
         base_vc_sel   <= c1_tx.vc_sel;
         base_cl_len   <= c1_tx.cl_len;
         base_mdata    <= c1_tx.mdata;
         base_req_type <= c1_tx.req_type;
      end
   end

endmodule

// File: rtl/ccip_sniffer.sv
// CCI-P protocol sniffer top level
// Three independent checkers, their flags merged into one error code
// MMIO_TIMEOUT passes through to the MMIO tracker
`timescale 1ns/1ps

module ccip_sniffer
   import sniffer_pkg::*;
#(
   parameter int MMIO_TIMEOUT = 512
) (
   input  logic      clk,
   input  logic      ase_reset,
   input  logic      soft_reset,
   input  c0_tx_t    c0_tx,
   input  c1_tx_t    c1_tx,
   input  mmio_req_t mmio_req,
   input  mmio_req_t mmio_rsp,
   input  logic      c0_full,
   input  logic      c1_full,
   output err_vec_t  error_code
);

   // Each vector only ever carries its own checker's bits
   err_vec_t c0_err;
   err_vec_t c1_err;
   err_vec_t mmio_err;

   c0_read_checker c0_read_checker_inst (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c0_tx      (c0_tx),
      .c0_full    (c0_full),
      .err        (c0_err)
   );

   c1_write_checker c1_write_checker_inst (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c1_tx      (c1_tx),
      .c1_full    (c1_full),
      .err        (c1_err)
   );

   mmio_rsp_tracker #(
      .MMIO_TIMEOUT (MMIO_TIMEOUT)
   ) mmio_rsp_tracker_inst (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .err        (mmio_err)
   );

   // Disjoint bit sets, OR merges them
   assign error_code = c0_err | c1_err | mmio_err;

endmodule

// File: rtl/mmio_rsp_tracker.sv
// Tracks outstanding MMIO reads per TID and checks their responses
// MMIO_TIMEOUT is the response deadline in cycles after the request edge
`timescale 1ns/1ps

module mmio_rsp_tracker
   import sniffer_pkg::*;
#(
   parameter int MMIO_TIMEOUT = 512
) (
   input  logic      clk,
   input  logic      ase_reset,
   input  logic      soft_reset,
   input  mmio_req_t mmio_req,
   input  mmio_req_t mmio_rsp,
   output err_vec_t  err
);

   localparam int DEPTH = 2 ** TID_WIDTH;
   localparam int CNT_W = $clog2(MMIO_TIMEOUT + 1);

   logic [DEPTH-1:0] timeout_hit;
   logic [DEPTH-1:0] unsol_hit;
   err_vec_t         err_next;

   for (genvar i = 0; i < DEPTH; i++) begin : g_entry
      logic             active;
      logic [CNT_W-1:0] cnt;
      logic             req_hit;
      logic             rsp_hit;

      assign req_hit = mmio_req.valid && (mmio_req.tid == TID_WIDTH'(i));
      assign rsp_hit = mmio_rsp.valid && (mmio_rsp.tid == TID_WIDTH'(i));

      // Last cycle before deadline, a response on this edge still counts
      assign timeout_hit[i] = active && !rsp_hit &&
                              (cnt == CNT_W'(MMIO_TIMEOUT - 1));
      assign unsol_hit[i]   = rsp_hit && !active;

      // Response is handled first, a same-cycle request then re-arms
      always_ff @(posedge clk) begin
         if (ase_reset || soft_reset) begin
            active <= 1'b0;
            cnt    <= '0;
         end else if (req_hit) begin
            active <= 1'b1;
            cnt    <= '0;
         end else if (rsp_hit) begin
            active <= 1'b0;
            cnt    <= '0;
         end else if (active && (cnt != CNT_W'(MMIO_TIMEOUT))) begin
            // Saturates at the deadline so timeout fires once
            cnt <= cnt + 1'b1;
         end
      end
   end

   always_comb begin
      err_next = '0;
      if (soft_reset) begin
         err_next[MMIO_RDRSP_RESET_IGNORED_WARN] = mmio_rsp.valid;
      end else begin
         err_next[MMIO_RDRSP_TIMEOUT]     = |timeout_hit;
         err_next[MMIO_RDRSP_UNSOLICITED] = |unsol_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         err <= '0;
      end else begin
         err <= err_next;
      end
   end

endmodule

// File: rtl/sniffer_pkg.sv
// Shared widths, request encodings and structs for the CCI-P sniffer
// Each RTL module imports this package in its header
package sniffer_pkg;

   // Bus widths
   localparam int CL_ADDR_WIDTH      = 42;
   localparam int MDATA_WIDTH        = 16;
   localparam int TID_WIDTH          = 9;
   localparam int SNIFF_VECTOR_WIDTH = 32;

   // Channel 0 read request encodings
   typedef enum logic [3:0] {
      REQ_RDLINE_S = 4'h0,
      REQ_RDLINE_I = 4'h1
   } c0_req_e;

   // Channel 1 write request encodings
   typedef enum logic [3:0] {
      REQ_WRLINE_I = 4'h0,
      REQ_WRLINE_M = 4'h1,
      REQ_WRPUSH_I = 4'h2,
      REQ_WRFENCE  = 4'h4
   } c1_req_e;

   // Line count, 3 lines is illegal
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'd0,
      CL_LEN_2 = 2'd1,
      CL_LEN_3 = 2'd2,
      CL_LEN_4 = 2'd3
   } cl_len_e;

   // Read request header plus valid
   typedef struct packed {
      logic                     valid;
      logic [1:0]               vc_sel;
      cl_len_e                  cl_len;
      c0_req_e                  req_type;
      logic [CL_ADDR_WIDTH-1:0] address;
      logic [MDATA_WIDTH-1:0]   mdata;
   } c0_tx_t;

   // Write request header plus valid
   typedef struct packed {
      logic                     valid;
      logic [1:0]               vc_sel;
      logic                     sop;
      cl_len_e                  cl_len;
      c1_req_e                  req_type;
      logic [CL_ADDR_WIDTH-1:0] address;
      logic [MDATA_WIDTH-1:0]   mdata;
   } c1_tx_t;

   // MMIO read request or response
   typedef struct packed {
      logic                 valid;
      logic [TID_WIDTH-1:0] tid;
   } mmio_req_t;

   // Write burst position, value is the beat offset from the base
   typedef enum logic [1:0] {
      C1_EXPECT_SOP = 2'd0,
      C1_BEAT_2     = 2'd1,
      C1_BEAT_3     = 2'd2,
      C1_BEAT_4     = 2'd3
   } c1_state_e;

   // Error code bit positions
   typedef enum logic [4:0] {
      SNIFF_C0TX_INVALID_REQTYPE    = 5'd0,
      SNIFF_C0TX_OVERFLOW           = 5'd1,
      SNIFF_C0TX_ADDRALIGN_2_ERROR  = 5'd2,
      SNIFF_C0TX_ADDRALIGN_4_ERROR  = 5'd3,
      SNIFF_C0TX_RESET_IGNORED_WARN = 5'd4,
      SNIFF_C0TX_3CL_REQUEST        = 5'd5,
      SNIFF_C0TX_ADDR_ZERO_WARN     = 5'd6,
      SNIFF_C1TX_INVALID_REQTYPE    = 5'd8,
      SNIFF_C1TX_OVERFLOW           = 5'd9,
      SNIFF_C1TX_ADDRALIGN_2_ERROR  = 5'd10,
      SNIFF_C1TX_ADDRALIGN_4_ERROR  = 5'd11,
      SNIFF_C1TX_RESET_IGNORED_WARN = 5'd12,
      SNIFF_C1TX_UNEXP_VCSEL        = 5'd13,
      SNIFF_C1TX_UNEXP_MDATA        = 5'd14,
      SNIFF_C1TX_UNEXP_ADDR         = 5'd15,
      SNIFF_C1TX_UNEXP_CLLEN        = 5'd16,
      SNIFF_C1TX_UNEXP_REQTYPE      = 5'd17,
      SNIFF_C1TX_SOP_NOT_SET        = 5'd18,
      SNIFF_C1TX_SOP_SET_MCL1TO3    = 5'd19,
      SNIFF_C1TX_3CL_REQUEST        = 5'd20,
      SNIFF_C1TX_WRFENCE_IN_MCL1TO3 = 5'd21,
      SNIFF_C1TX_WRFENCE_SOP_SET    = 5'd22,
      SNIFF_C1TX_ADDR_ZERO_WARN     = 5'd23,
      MMIO_RDRSP_TIMEOUT            = 5'd24,
      MMIO_RDRSP_UNSOLICITED        = 5'd25,
      MMIO_RDRSP_RESET_IGNORED_WARN = 5'd26
   } sniff_code_e;

   typedef logic [SNIFF_VECTOR_WIDTH-1:0] err_vec_t;

endpackage

// File: tests/sniffer_props.sv
// Concurrent assertions on the sniffer top level
// Attached to ccip_sniffer by the bind at the end of this file
`timescale 1ns/1ps

module sniffer_props
   import sniffer_pkg::*;
(
   input logic     clk,
   input logic     ase_reset,
   input c1_tx_t   c1_tx,
   input err_vec_t error_code
);

   // Bits 7 and 27 to 31 carry no rule
   localparam err_vec_t UNUSED_MASK = 32'hF800_0080;
   // Channel 1 rule bits 8 to 23
   localparam err_vec_t C1_MASK     = 32'h00FF_FF00;

   a_reset_clears: assert property (@(posedge clk) ase_reset |=> (error_code == '0))
      else $error("error_code not zero after ase_reset");

   a_unused_bits: assert property (@(posedge clk) disable iff (ase_reset)
      ((error_code & UNUSED_MASK) == '0))
      else $error("unused error_code bit set");

   // Flags only follow a sampled beat
   a_c1_needs_beat: assert property (@(posedge clk) disable iff (ase_reset)
      !c1_tx.valid |=> ((error_code & C1_MASK) == '0))
      else $error("channel 1 flag without a channel 1 beat");

endmodule

bind ccip_sniffer sniffer_props sniffer_props_inst (
   .clk        (clk),
   .ase_reset  (ase_reset),
   .c1_tx      (c1_tx),
   .error_code (error_code)
);

// File: tests/sniffer_tb.sv
// Testbench for the CCI-P sniffer top level
// Directed rule tests per channel followed by seeded random traffic
// A reference model predicts error_code for every clock edge
`timescale 1ns/1ps

module sniffer_tb
   import sniffer_pkg::*;
();

   localparam int TIMEOUT_CYC   = 16;
   localparam int RANDOM_CYCLES = 400;
   localparam int WAIT_LIMIT    = 40;
   // Mostly legal write types for random traffic
   // 4'h9 is the one invalid code
   localparam logic [3:0] C1_TYPES [8] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h0, 4'h1, 4'h4, 4'h9};

   logic      clk = 1'b0;
   logic      ase_reset;
   logic      soft_reset;
   logic      c0_full;
   logic      c1_full;
   c0_tx_t    c0_tx;
   c1_tx_t    c1_tx;
   mmio_req_t mmio_req;
   mmio_req_t mmio_rsp;
   err_vec_t  error_code;

   // Reference model state
   // m_beat is 0 while waiting for sop and the beat number otherwise
   int          m_beat;
   logic [1:0]  m_addr_low;
   logic [1:0]  m_vc;
   cl_len_e     m_len;
   logic [15:0] m_mdata;
   logic [3:0]  m_type;
   logic        m_active [512];
   int          m_req_edge [512];
   int          edge_cnt = 0;
   err_vec_t    pred;
   logic        pred_valid = 1'b0;

   int seed = 41;
   int errors = 0;
   int checks = 0;
   int tests_run = 0;
   int test_mark = 0;

   ccip_sniffer #(
      .MMIO_TIMEOUT (TIMEOUT_CYC)
   ) ccip_sniffer_inst (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c0_tx      (c0_tx),
      .c1_tx      (c1_tx),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .c0_full    (c0_full),
      .c1_full    (c1_full),
      .error_code (error_code)
   );

   always #20 clk = ~clk;

   function automatic err_vec_t bit_mask(input sniff_code_e code);
      err_vec_t m;
      m = '0;
      m[code] = 1'b1;
      return m;
   endfunction

   // Expected flags for the coming edge from current inputs and model state
   function automatic err_vec_t expected_code();
      err_vec_t   e;
      logic [1:0] exp_low;
      e = '0;
      if (ase_reset) begin
         return e;
      end
      if (c0_tx.valid && soft_reset) begin
         e[SNIFF_C0TX_RESET_IGNORED_WARN] = 1'b1;
      end else if (c0_tx.valid) begin
         e[SNIFF_C0TX_INVALID_REQTYPE] = !(c0_tx.req_type inside {REQ_RDLINE_S, REQ_RDLINE_I});
         e[SNIFF_C0TX_OVERFLOW]        = c0_full;
         e[SNIFF_C0TX_3CL_REQUEST]     = (c0_tx.cl_len == CL_LEN_3);
         e[SNIFF_C0TX_ADDRALIGN_2_ERROR] = (c0_tx.cl_len == CL_LEN_2) && c0_tx.address[0];
         e[SNIFF_C0TX_ADDRALIGN_4_ERROR] = (c0_tx.cl_len == CL_LEN_4) &&
                                           (c0_tx.address[1:0] != 2'b00);
         e[SNIFF_C0TX_ADDR_ZERO_WARN]  = (c0_tx.address == '0);
      end
      if (c1_tx.valid && soft_reset) begin
         e[SNIFF_C1TX_RESET_IGNORED_WARN] = 1'b1;
      end else if (c1_tx.valid) begin
         e[SNIFF_C1TX_OVERFLOW] = c1_full;
         if (!(c1_tx.req_type inside {REQ_WRLINE_I, REQ_WRLINE_M, REQ_WRPUSH_I, REQ_WRFENCE}))
         begin
            e[SNIFF_C1TX_INVALID_REQTYPE] = 1'b1;
         end else if (c1_tx.req_type == REQ_WRFENCE) begin
            e[SNIFF_C1TX_WRFENCE_SOP_SET]    = c1_tx.sop;
            e[SNIFF_C1TX_WRFENCE_IN_MCL1TO3] = (m_beat != 0);
         end else if (m_beat == 0) begin
            e[SNIFF_C1TX_SOP_NOT_SET] = !c1_tx.sop;
            if (c1_tx.sop) begin
               e[SNIFF_C1TX_3CL_REQUEST] = (c1_tx.cl_len == CL_LEN_3);
               e[SNIFF_C1TX_ADDRALIGN_2_ERROR] = (c1_tx.cl_len == CL_LEN_2) &&
                                                 c1_tx.address[0];
               e[SNIFF_C1TX_ADDRALIGN_4_ERROR] = (c1_tx.cl_len == CL_LEN_4) &&
                                                 (c1_tx.address[1:0] != 2'b00);
               e[SNIFF_C1TX_ADDR_ZERO_WARN] = (c1_tx.address == '0);
            end
         end else begin
            // Beat k sits k-1 lines above the base
            exp_low = m_addr_low + 2'(m_beat - 1);
            e[SNIFF_C1TX_UNEXP_ADDR]      = (c1_tx.address[1:0] != exp_low);
            e[SNIFF_C1TX_UNEXP_CLLEN]     = (c1_tx.cl_len != m_len);
            e[SNIFF_C1TX_UNEXP_VCSEL]     = (c1_tx.vc_sel != m_vc);
            e[SNIFF_C1TX_UNEXP_MDATA]     = (c1_tx.mdata != m_mdata);
            e[SNIFF_C1TX_UNEXP_REQTYPE]   = (c1_tx.req_type != m_type);
            e[SNIFF_C1TX_SOP_SET_MCL1TO3] = c1_tx.sop;
         end
      end
      if (soft_reset) begin
         e[MMIO_RDRSP_RESET_IGNORED_WARN] = mmio_rsp.valid;
      end else begin
         e[MMIO_RDRSP_UNSOLICITED] = mmio_rsp.valid && !m_active[mmio_rsp.tid];
         for (int t = 0; t < 512; t++) begin
            // Deadline edge unless answered on that same edge
            if (m_active[t] && (edge_cnt - m_req_edge[t] == TIMEOUT_CYC) &&
                !(mmio_rsp.valid && (int'(mmio_rsp.tid) == t))) begin
               e[MMIO_RDRSP_TIMEOUT] = 1'b1;
            end
         end
      end
      return e;
   endfunction

   // Model state after the coming edge
   task automatic advance_model();
      if (ase_reset || soft_reset) begin
         m_beat = 0;
         for (int t = 0; t < 512; t++) begin
            m_active[t] = 1'b0;
         end
      end else begin
         if (c1_tx.valid && (c1_tx.req_type inside {REQ_WRLINE_I, REQ_WRLINE_M, REQ_WRPUSH_I}))
         begin
            if (m_beat == 0) begin
               if (c1_tx.sop) begin
                  m_addr_low = c1_tx.address[1:0];
                  m_vc       = c1_tx.vc_sel;
                  m_len      = c1_tx.cl_len;
                  m_mdata    = c1_tx.mdata;
                  m_type     = c1_tx.req_type;
                  m_beat     = (c1_tx.cl_len inside {CL_LEN_2, CL_LEN_4}) ? 2 : 0;
               end
            end else if (m_beat == 2 && m_len == CL_LEN_4) begin
               m_beat = 3;
            end else if (m_beat == 3) begin
               m_beat = 4;
            end else begin
               m_beat = 0;
            end
         end
         // Response clears first and a request on the same TID re-arms it
         if (mmio_rsp.valid) begin
            m_active[mmio_rsp.tid] = 1'b0;
         end
         if (mmio_req.valid) begin
            m_active[mmio_req.tid]   = 1'b1;
            m_req_edge[mmio_req.tid] = edge_cnt;
         end
      end
      edge_cnt++;
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                  $time, msg, actual, expected);
      end
   endtask

   // Inputs settle well before the falling edge
   // Outputs there still show the last rising edge
   always @(negedge clk) begin
      if (pred_valid) begin
         check_value(error_code, pred, "error_code against reference");
      end
      pred       = expected_code();
      pred_valid = 1'b1;
      advance_model();
   end

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic idle();
      c0_tx.valid    = 1'b0;
      c1_tx.valid    = 1'b0;
      mmio_req.valid = 1'b0;
      mmio_rsp.valid = 1'b0;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      $display("%-18s %s, %0d errors", name, (errors == test_mark) ? "ok" : "bad",
               errors - test_mark);
      test_mark = errors;
   endtask

   // Drive one beat and check the flags just after its sampling edge
   task automatic c0_beat(input cl_len_e len, input logic [3:0] rtype,
                          input logic [41:0] addr, input err_vec_t exp, input string msg);
      c0_tx = '{valid: 1'b1, vc_sel: 2'd0, cl_len: len, req_type: c0_req_e'(rtype),
                address: addr, mdata: 16'h1};
      step();
      idle();
      check_value(error_code, exp, msg);
   endtask

   task automatic c1_beat(input logic sop, input cl_len_e len, input c1_req_e rtype,
                          input logic [41:0] addr, input logic [1:0] vc,
                          input logic [15:0] md, input err_vec_t exp, input string msg);
      c1_tx = '{valid: 1'b1, vc_sel: vc, sop: sop, cl_len: len, req_type: rtype,
                address: addr, mdata: md};
      step();
      idle();
      check_value(error_code, exp, msg);
   endtask

   task automatic mmio_beat(input logic is_req, input logic [8:0] tid,
                            input err_vec_t exp, input string msg);
      if (is_req) begin
         mmio_req = '{valid: 1'b1, tid: tid};
      end else begin
         mmio_rsp = '{valid: 1'b1, tid: tid};
      end
      step();
      idle();
      check_value(error_code, exp, msg);
   endtask

   task automatic clean_traffic();
      check_value(error_code, '0, "error_code after reset");
      c0_beat(CL_LEN_1, 4'h0, 42'h100, '0, "1-line read");
      c0_beat(CL_LEN_2, 4'h1, 42'h102, '0, "2-line read");
      c0_beat(CL_LEN_4, 4'h0, 42'h104, '0, "4-line read");
      c1_beat(1'b1, CL_LEN_1, REQ_WRLINE_I, 42'h200, 2'd1, 16'h55, '0, "1-line write");
      c1_beat(1'b1, CL_LEN_2, REQ_WRLINE_M, 42'h202, 2'd1, 16'h55, '0, "2-line beat 1");
      c1_beat(1'b0, CL_LEN_2, REQ_WRLINE_M, 42'h203, 2'd1, 16'h55, '0, "2-line beat 2");
      for (int k = 0; k < 4; k++) begin
         c1_beat(k == 0, CL_LEN_4, REQ_WRPUSH_I, 42'h204 + 42'(k), 2'd1, 16'h55, '0,
                 "4-line burst beat");
      end
      finish_test("clean traffic");
   endtask

   task automatic c0_rules();
      c0_beat(CL_LEN_1, 4'h5, 42'h100, bit_mask(SNIFF_C0TX_INVALID_REQTYPE), "bad read type");
      c0_beat(CL_LEN_3, 4'h0, 42'h100, bit_mask(SNIFF_C0TX_3CL_REQUEST), "3-line read");
      c0_beat(CL_LEN_2, 4'h0, 42'h101, bit_mask(SNIFF_C0TX_ADDRALIGN_2_ERROR), "2-line align");
      c0_beat(CL_LEN_4, 4'h1, 42'h102, bit_mask(SNIFF_C0TX_ADDRALIGN_4_ERROR), "4-line align");
      c0_beat(CL_LEN_1, 4'h0, 42'h0, bit_mask(SNIFF_C0TX_ADDR_ZERO_WARN), "zero read address");
      c0_full = 1'b1;
      c0_beat(CL_LEN_1, 4'h0, 42'h100, bit_mask(SNIFF_C0TX_OVERFLOW), "read while full");
      c0_full    = 1'b0;
      soft_reset = 1'b1;
      c0_beat(CL_LEN_1, 4'h0, 42'h100, bit_mask(SNIFF_C0TX_RESET_IGNORED_WARN),
              "read in soft reset");
      soft_reset = 1'b0;
      finish_test("channel 0 rules");
   endtask

   task automatic c1_sequence();
      c1_beat(1'b0, CL_LEN_1, REQ_WRLINE_I, 42'h300, 2'd1, 16'h55,
              bit_mask(SNIFF_C1TX_SOP_NOT_SET), "write without sop");
      c1_beat(1'b1, CL_LEN_2, REQ_WRLINE_I, 42'h300, 2'd1, 16'h55, '0, "burst start");
      c1_beat(1'b1, CL_LEN_2, REQ_WRLINE_I, 42'h301, 2'd1, 16'h55,
              bit_mask(SNIFF_C1TX_SOP_SET_MCL1TO3), "sop on beat 2");
      c1_beat(1'b1, CL_LEN_2, REQ_WRLINE_I, 42'h300, 2'd1, 16'h55, '0, "burst start");
      c1_beat(1'b0, CL_LEN_2, REQ_WRLINE_I, 42'h300, 2'd1, 16'h55,
              bit_mask(SNIFF_C1TX_UNEXP_ADDR), "wrong beat address");
      c1_beat(1'b1, CL_LEN_4, REQ_WRLINE_I, 42'h304, 2'd1, 16'h55, '0, "4-line start");
      c1_beat(1'b0, CL_LEN_4, REQ_WRLINE_I, 42'h305, 2'd2, 16'h55,
              bit_mask(SNIFF_C1TX_UNEXP_VCSEL), "changed vc_sel");
      c1_beat(1'b0, CL_LEN_4, REQ_WRLINE_I, 42'h306, 2'd1, 16'h56,
              bit_mask(SNIFF_C1TX_UNEXP_MDATA), "changed mdata");
      c1_beat(1'b0, CL_LEN_2, REQ_WRLINE_I, 42'h307, 2'd1, 16'h55,
              bit_mask(SNIFF_C1TX_UNEXP_CLLEN), "changed cl_len");
      c1_beat(1'b1, CL_LEN_2, REQ_WRLINE_I, 42'h308, 2'd1, 16'h55, '0, "burst start");
      c1_beat(1'b0, CL_LEN_2, REQ_WRLINE_M, 42'h309, 2'd1, 16'h55,
              bit_mask(SNIFF_C1TX_UNEXP_REQTYPE), "changed req_type");
      c1_beat(1'b1, CL_LEN_4, REQ_WRLINE_I, 42'h30C, 2'd1, 16'h55, '0, "4-line start");
      c1_beat(1'b0, CL_LEN_1, REQ_WRFENCE, 42'h0, 2'd1, 16'h55,
              bit_mask(SNIFF_C1TX_WRFENCE_IN_MCL1TO3), "fence inside burst");
      // Fence left the burst where it was
      for (int k = 1; k < 4; k++) begin
         c1_beat(1'b0, CL_LEN_4, REQ_WRLINE_I, 42'h30C + 42'(k), 2'd1, 16'h55, '0,
                 "burst after fence");
      end
      c1_beat(1'b1, CL_LEN_1, REQ_WRFENCE, 42'h0, 2'd1, 16'h55,
              bit_mask(SNIFF_C1TX_WRFENCE_SOP_SET), "fence with sop");
      c1_beat(1'b1, CL_LEN_2, REQ_WRPUSH_I, 42'h310, 2'd3, 16'h77, '0, "clean burst beat 1");
      c1_beat(1'b0, CL_LEN_2, REQ_WRPUSH_I, 42'h311, 2'd3, 16'h77, '0, "clean burst beat 2");
      finish_test("channel 1 sequence");
   endtask

   task automatic mmio_tracking();
      int cycles;
      mmio_beat(1'b0, 9'd5, bit_mask(MMIO_RDRSP_UNSOLICITED), "response without request");
      mmio_beat(1'b1, 9'd7, '0, "MMIO request");
      repeat (5) step();
      mmio_beat(1'b0, 9'd7, '0, "response in time");
      repeat (TIMEOUT_CYC + 4) step();
      mmio_beat(1'b1, 9'd9, '0, "request left open");
      cycles = 0;
      while (!error_code[MMIO_RDRSP_TIMEOUT] && cycles < WAIT_LIMIT) begin
         step();
         cycles++;
      end
      if (!error_code[MMIO_RDRSP_TIMEOUT]) begin
         errors++;
         $display("MMIO timeout flag did not rise within %0d cycles", WAIT_LIMIT);
      end else begin
         check_value(cycles, TIMEOUT_CYC, "cycles from request to timeout flag");
      end
      mmio_beat(1'b0, 9'd9, '0, "late response");
      soft_reset = 1'b1;
      mmio_beat(1'b0, 9'd3, bit_mask(MMIO_RDRSP_RESET_IGNORED_WARN), "response in soft reset");
      soft_reset = 1'b0;
      finish_test("MMIO tracking");
   endtask

   task automatic random_traffic();
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      repeat (RANDOM_CYCLES) begin
         r1 = $random(seed);
         r2 = $random(seed);
         r3 = $random(seed);
         soft_reset = (r3[4:0] == 5'd0);
         c0_full    = (r3[7:5] == 3'd0);
         c1_full    = (r3[10:8] == 3'd0);
         c0_tx.valid    = r1[0];
         c0_tx.cl_len   = cl_len_e'(r1[2:1]);
         c0_tx.req_type = c0_req_e'((r1[5:3] == 3'd0) ? 4'hA : {3'b000, r1[6]});
         c0_tx.address  = (r1[9:7] == 3'd0) ? '0 : {r1[31:16], 24'h0, r1[11:10]};
         c0_tx.vc_sel   = r1[13:12];
         c0_tx.mdata    = r1[31:16];
         c1_tx.valid    = r2[0];
         c1_tx.sop      = r2[1];
         c1_tx.cl_len   = cl_len_e'(r2[3:2]);
         c1_tx.req_type = c1_req_e'(C1_TYPES[r2[6:4]]);
         c1_tx.address  = (r2[9:7] == 3'd0) ? '0 : {40'h80, r2[11:10]};
         // Mostly repeated header fields so that some bursts stay clean
         c1_tx.vc_sel   = (r2[13:12] == 2'd0) ? 2'd2 : 2'd1;
         c1_tx.mdata    = (r2[15:14] == 2'd0) ? 16'h7 : 16'h5;
         mmio_req = '{valid: r3[11] & r3[12], tid: {6'd0, r3[15:13]}};
         mmio_rsp = '{valid: r3[16] & r3[17] & r3[18], tid: {6'd0, r3[21:19]}};
         step();
      end
      idle();
      soft_reset = 1'b0;
      c0_full    = 1'b0;
      c1_full    = 1'b0;
      // Open requests run out their deadline
      repeat (TIMEOUT_CYC + 4) step();
      finish_test("random traffic");
   endtask

   initial begin
      ase_reset  = 1'b1;
      soft_reset = 1'b0;
      c0_full    = 1'b0;
      c1_full    = 1'b0;
      c0_tx      = '0;
      c1_tx      = '0;
      mmio_req   = '0;
      mmio_rsp   = '0;
      repeat (8) @(posedge clk);
      #2;
      ase_reset = 1'b0;
      clean_traffic();
      c0_rules();
      c1_sequence();
      mmio_tracking();
      random_traffic();
      $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
